// ==== hw/usiPkg.sv ====
`default_nettype none

package usiPkg;

	// --------------------
	// Bus widths
	// --------------------
	localparam int usiDataWidth   = 32;
	localparam int blockAdrsWidth = 4;
	localparam int csrAdrsWidth   = 8;

	// Block address of block 0, address 0 stays unmapped
	localparam logic [blockAdrsWidth-1:0] blockBase = blockAdrsWidth'(1);

	// --------------------
	// Bus words
	// --------------------
	// Block field on top, CSR index below
	typedef struct packed
	{
		logic [blockAdrsWidth-1:0] block;
		logic [csrAdrsWidth-1:0]   csr;
	} usiAdrs_t;

	// Master request
	typedef struct packed
	{
		logic                    write;
		usiAdrs_t                adrs;
		logic [usiDataWidth-1:0] wd;
	} usiReq_t;

	// Response back to the master
	typedef struct packed
	{
		logic [usiDataWidth-1:0] rd;
		logic                    miss;
	} usiRsp_t;

	// Cycle seen by every block, block field already decoded
	typedef struct packed
	{
		logic                    write;
		logic [csrAdrsWidth-1:0] csr;
		logic [usiDataWidth-1:0] wd;
	} usiCyc_t;

endpackage

`default_nettype wire

// ==== hw/usiMasterPort.sv ====
`default_nettype none

module usiMasterPort
	import usiPkg::*;
(
	input  logic    sysClk,
	input  logic    arstN,
	// External four-phase port
	input  logic    req,
	input  usiReq_t reqData,
	output logic    ack,
	output usiRsp_t rsp,
	// Bus side
	output logic    cycValid,
	output usiReq_t cycReq,
	input  logic    rspValid,
	input  usiRsp_t rspIn
);

	typedef enum logic [1:0]
	{
		stIdle,
		stBusy,
		stAcked
	} portState_t;

	portState_t state;

	// --------------------
	// Handshake FSM
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state    <= stIdle;
			ack      <= 1'b0;
			cycValid <= 1'b0;
		end
		else
		begin
			cycValid <= 1'b0;
			case (state)
				stIdle:
				begin
					// Ack is low here, so a new request may start
					if (req)
					begin
						cycValid <= 1'b1;
						state    <= stBusy;
					end
				end
				stBusy:
				begin
					if (rspValid)
					begin
						ack   <= 1'b1;
						state <= stAcked;
					end
				end
				stAcked:
				begin
					// Hold until the environment releases req
					if (!req)
					begin
						ack   <= 1'b0;
						state <= stIdle;
					end
				end
				default:
				begin
					ack   <= 1'b0;
					state <= stIdle;
				end
			endcase
		end
	end

	// --------------------
	// Request and response latches
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (state == stIdle && req)
			cycReq <= reqData;
		// Response stays put for the whole ack phase
		if (state == stBusy && rspValid)
			rsp <= rspIn;
	end

endmodule

`default_nettype wire

// ==== hw/usiDecoder.sv ====
`default_nettype none

module usiDecoder
	import usiPkg::*;
#(
	parameter int pBlockCount = 4
)(
	input  logic                   sysClk,
	input  logic                   arstN,
	input  logic                   cycValid,
	input  usiReq_t                cycReq,
	output usiCyc_t                cyc,
	output logic [pBlockCount-1:0] blockSel,
	output logic                   miss
);

	logic [blockAdrsWidth-1:0] blockIdx;
	logic                      blockHit;
	logic [pBlockCount-1:0]    selNext;

	// Block index and range check
	always_comb
	begin
		blockIdx = cycReq.adrs.block - blockBase;
		blockHit = (cycReq.adrs.block >= blockBase) && (int'(blockIdx) < pBlockCount);
		for (int i = 0; i < pBlockCount; i++)
			selNext[i] = blockHit && (int'(blockIdx) == i);
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			blockSel <= '0;
			miss     <= 1'b0;
		end
		else
		begin
			blockSel <= cycValid ? selNext : '0;
			miss     <= cycValid && !blockHit;
		end
	end

	// Broadcast cycle to all blocks
	always_ff @(posedge sysClk)
	begin
		if (cycValid)
		begin
			cyc.write <= cycReq.write;
			cyc.csr   <= cycReq.adrs.csr;
			cyc.wd    <= cycReq.wd;
		end
	end

endmodule

`default_nettype wire

// ==== hw/csrBlock.sv ====
`default_nettype none

module csrBlock
	import usiPkg::*;
#(
	parameter int pCsrDepth = 4
)(
	input  logic                    sysClk,
	input  logic                    arstN,
	input  logic                    sel,
	input  usiCyc_t                 cyc,
	output logic                    rdValid,
	output logic [usiDataWidth-1:0] rd,
	output logic [7:0]              outByte
);

	localparam int csrIdxWidth = (pCsrDepth > 1) ? $clog2(pCsrDepth) : 1;

	logic [usiDataWidth-1:0] regFile [pCsrDepth];
	logic [csrIdxWidth-1:0]  csrIdx;
	logic                    csrHit;

	// CSR index past the file is ignored
	assign csrIdx = cyc.csr[csrIdxWidth-1:0];
	assign csrHit = int'(cyc.csr) < pCsrDepth;

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < pCsrDepth; i++)
				regFile[i] <= '0;
		end
		else if (sel && cyc.write && csrHit)
			regFile[csrIdx] <= cyc.wd;
	end

	// --------------------
	// Response
	// --------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			rdValid <= 1'b0;
		else
			rdValid <= sel;
	end

	// A write echoes the value just written
	always_ff @(posedge sysClk)
	begin
		if (sel)
		begin
			if (!csrHit)
				rd <= '0;
			else if (cyc.write)
				rd <= cyc.wd;
			else
				rd <= regFile[csrIdx];
		end
	end

	// Register 0 low byte drives the output pins
	assign outByte = regFile[0][7:0];

endmodule

`default_nettype wire

// ==== hw/usiReadMux.sv ====
`default_nettype none

module usiReadMux
	import usiPkg::*;
#(
	parameter int pBlockCount = 4
)(
	input  logic                                     sysClk,
	input  logic                                     arstN,
	input  logic [pBlockCount-1:0]                   rdValid,
	input  logic [pBlockCount-1:0][usiDataWidth-1:0] rd,
	input  logic                                     miss,
	output logic                                     rspValid,
	output usiRsp_t                                  rsp
);

	logic [usiDataWidth-1:0] rdOr;
	logic                    missDly;
	logic                    anyValid;

	// Only the answering block contributes
	always_comb
	begin
		rdOr = '0;
		for (int i = 0; i < pBlockCount; i++)
			if (rdValid[i])
				rdOr = rdOr | rd[i];
	end

	assign anyValid = (|rdValid) || missDly;

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			missDly  <= 1'b0;
			rspValid <= 1'b0;
		end
		else
		begin
			// Decoder miss comes one stage ahead of the block answers
			missDly  <= miss;
			rspValid <= anyValid;
		end
	end

	// Miss gives zero data with the flag set
	always_ff @(posedge sysClk)
	begin
		if (anyValid)
		begin
			rsp.rd   <= missDly ? '0 : rdOr;
			rsp.miss <= missDly;
		end
	end

endmodule

`default_nettype wire

// ==== hw/usiSystem.sv ====
`default_nettype none

module usiSystem
	import usiPkg::*;
#(
	parameter int pBlockCount = 4,
	parameter int pCsrDepth   = 4
)(
	input  logic                        sysClk,
	input  logic                        arstN,
	input  logic                        req,
	input  usiReq_t                     reqData,
	output logic                        ack,
	output usiRsp_t                     rsp,
	output logic [pBlockCount-1:0][7:0] blockOut
);

	// --------------------
	// Bus wiring
	// --------------------
	logic                                     cycValid;
	usiReq_t                                  cycReq;
	usiCyc_t                                  cyc;
	logic [pBlockCount-1:0]                   blockSel;
	logic                                     decMiss;
	logic [pBlockCount-1:0]                   blockRdValid;
	logic [pBlockCount-1:0][usiDataWidth-1:0] blockRd;
	logic                                     rspValid;
	usiRsp_t                                  rspBus;

	usiMasterPort usiMasterPort (
		.sysClk   (sysClk),
		.arstN    (arstN),
		.req      (req),
		.reqData  (reqData),
		.ack      (ack),
		.rsp      (rsp),
		.cycValid (cycValid),
		.cycReq   (cycReq),
		.rspValid (rspValid),
		.rspIn    (rspBus)
	);

	usiDecoder #(
		.pBlockCount (pBlockCount)
	) usiDecoder (
		.sysClk   (sysClk),
		.arstN    (arstN),
		.cycValid (cycValid),
		.cycReq   (cycReq),
		.cyc      (cyc),
		.blockSel (blockSel),
		.miss     (decMiss)
	);

	// One register block per bus slot
	for (genvar i = 0; i < pBlockCount; i++)
	begin : gBlock
		csrBlock #(
			.pCsrDepth (pCsrDepth)
		) csrBlock (
			.sysClk  (sysClk),
			.arstN   (arstN),
			.sel     (blockSel[i]),
			.cyc     (cyc),
			.rdValid (blockRdValid[i]),
			.rd      (blockRd[i]),
			.outByte (blockOut[i])
		);
	end

	usiReadMux #(
		.pBlockCount (pBlockCount)
	) usiReadMux (
		.sysClk   (sysClk),
		.arstN    (arstN),
		.rdValid  (blockRdValid),
		.rd       (blockRd),
		.miss     (decMiss),
		.rspValid (rspValid),
		.rsp      (rspBus)
	);

endmodule

`default_nettype wire

// ==== testbench/usiSystem_chk.sv ====
`default_nettype none

module usiSystemChk
#(
	parameter int pBlockCount = 4
)(
	input logic                   sysClk,
	input logic                   arstN,
	input logic                   req,
	input logic                   ack,
	input logic [pBlockCount-1:0] blockSel,
	input logic [pBlockCount-1:0] rdValid
);

	timeunit 1ns;
	timeprecision 100ps;

	// --------------------
	// Handshake
	// --------------------
	// Ack only rises in answer to a pending request
	ackNeedsReq: assert property (@(posedge sysClk) disable iff (!arstN)
		$rose(ack) |-> $past(req))
	else
		$error("ack rose while req was low");

	// --------------------
	// Fabric
	// --------------------
	oneBlockSel: assert property (@(posedge sysClk) disable iff (!arstN)
		$onehot0(blockSel))
	else
		$error("blockSel has more than one bit set");

	oneRdValid: assert property (@(posedge sysClk) disable iff (!arstN)
		$onehot0(rdValid))
	else
		$error("more than one block raised rdValid");

endmodule

bind usiSystem usiSystemChk #(
	.pBlockCount (pBlockCount)
) chk (
	.sysClk   (sysClk),
	.arstN    (arstN),
	.req      (req),
	.ack      (ack),
	.blockSel (blockSel),
	.rdValid  (blockRdValid)
);

`default_nettype wire

// ==== testbench/usiSystemTb.sv ====
`default_nettype none

module usiSystemTb
	import usiPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// Must match the DUT defaults
	localparam int blockCount  = 4;
	localparam int csrDepth    = 4;
	localparam int clkPeriodNs = 8;
	localparam int resetCycles = 5;
	localparam int ackDelay    = 4;
	localparam int ackLimit    = 16;

	// Transactions per test, used to size the watchdog
	localparam int regCount    = blockCount * csrDepth;
	localparam int txnTotal    = regCount + 2 * regCount + (4 + regCount)
		+ (2 * blockCount + regCount);
	localparam int watchdogNs  = (resetCycles + txnTotal * 20) * clkPeriodNs;

	logic                       sysClk;
	logic                       arstN;
	logic                       req;
	usiReq_t                    reqData;
	logic                       ack;
	usiRsp_t                    rsp;
	logic [blockCount-1:0][7:0] blockOut;

	// Expected register contents
	logic [usiDataWidth-1:0] model [blockCount][csrDepth];
	logic [31:0]             lcgState;

	usiSystem uut (
		.sysClk   (sysClk),
		.arstN    (arstN),
		.req      (req),
		.reqData  (reqData),
		.ack      (ack),
		.rsp      (rsp),
		.blockOut (blockOut)
	);

	always #(clkPeriodNs / 2) sysClk = ~sysClk;

	// --------------------
	// Failure and compare
	// --------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkRsp(input string name, input usiRsp_t got, input usiRsp_t exp);
		if (got !== exp)
		begin
			abortRun($sformatf("error at %0d ns: %s got rd=%h miss=%b, expected rd=%h miss=%b",
				$time, name, got.rd, got.miss, exp.rd, exp.miss));
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abortRun($sformatf("error at %0d ns: %s got %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("error at %0d ns: %s got %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkCycles(input string name, input int got, input int exp);
		if (got != exp)
			abortRun($sformatf("error at %0d ns: %s got %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic blockMapped(input logic [blockAdrsWidth-1:0] field);
		int idx;
		idx = int'(field) - int'(blockBase);
		return (idx >= 0) && (idx < blockCount);
	endfunction

	// --------------------
	// Handshake
	// --------------------
	// Called 1 ns after a rising edge, returns 1 ns after the edge where ack fell
	task automatic runHandshake(input usiReq_t rq, output usiRsp_t got);
		int waitCycles;
		reqData = rq;
		req     = 1'b1;
		// Edge that first samples req
		@(posedge sysClk);
		#1;
		waitCycles = 0;
		while (!ack)
		begin
			if (waitCycles >= ackLimit)
				abortRun($sformatf("No ack within %0d cycles of req at %0d ns", ackLimit, $time));
			@(posedge sysClk);
			#1;
			waitCycles++;
		end
		checkCycles("ack delay", waitCycles, ackDelay);
		got = rsp;
		// Keep req high a while, the port must hold
		repeat (2)
		begin
			@(posedge sysClk);
			#1;
			checkLevel("ack while req held", ack, 1'b1);
			checkRsp("rsp while ack high", rsp, got);
		end
		req = 1'b0;
		@(posedge sysClk);
		#1;
		checkLevel("ack after req drop", ack, 1'b0);
	endtask

	task automatic doWrite(input logic [blockAdrsWidth-1:0] field,
		input logic [csrAdrsWidth-1:0] csr, input logic [usiDataWidth-1:0] wd,
		output usiRsp_t got);
		usiReq_t rq;
		rq.write      = 1'b1;
		rq.adrs.block = field;
		rq.adrs.csr   = csr;
		rq.wd         = wd;
		runHandshake(rq, got);
	endtask

	task automatic doRead(input logic [blockAdrsWidth-1:0] field,
		input logic [csrAdrsWidth-1:0] csr, output usiRsp_t got);
		usiReq_t rq;
		rq.write      = 1'b0;
		rq.adrs.block = field;
		rq.adrs.csr   = csr;
		rq.wd         = '0;
		runHandshake(rq, got);
	endtask

	// --------------------
	// Expected responses
	// --------------------
	task automatic writeAndCheck(input logic [blockAdrsWidth-1:0] field,
		input logic [csrAdrsWidth-1:0] csr, input logic [usiDataWidth-1:0] wd);
		usiRsp_t got;
		usiRsp_t exp;
		int      idx;
		idx      = int'(field) - int'(blockBase);
		exp.rd   = '0;
		exp.miss = 1'b0;
		if (!blockMapped(field))
			exp.miss = 1'b1;
		else if (int'(csr) < csrDepth)
		begin
			exp.rd = wd;
			model[idx][int'(csr)] = wd;
		end
		doWrite(field, csr, wd, got);
		checkRsp($sformatf("write rsp field %0d csr %0d", field, csr), got, exp);
	endtask

	task automatic readAndCheck(input logic [blockAdrsWidth-1:0] field,
		input logic [csrAdrsWidth-1:0] csr);
		usiRsp_t got;
		usiRsp_t exp;
		int      idx;
		idx      = int'(field) - int'(blockBase);
		exp.rd   = '0;
		exp.miss = 1'b0;
		if (!blockMapped(field))
			exp.miss = 1'b1;
		else if (int'(csr) < csrDepth)
			exp.rd = model[idx][int'(csr)];
		doRead(field, csr, got);
		checkRsp($sformatf("read rsp field %0d csr %0d", field, csr), got, exp);
	endtask

	task automatic readAllBack();
		for (int b = 0; b < blockCount; b++)
			for (int c = 0; c < csrDepth; c++)
				readAndCheck(blockAdrsWidth'(b) + blockBase, csrAdrsWidth'(c));
	endtask

	task automatic checkOutBytes();
		for (int b = 0; b < blockCount; b++)
			checkByte($sformatf("blockOut[%0d]", b), blockOut[b], model[b][0][7:0]);
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic testResetState();
		readAllBack();
		checkOutBytes();
	endtask

	task automatic testWriteReadBack();
		for (int b = 0; b < blockCount; b++)
			for (int c = 0; c < csrDepth; c++)
				writeAndCheck(blockAdrsWidth'(b) + blockBase, csrAdrsWidth'(c), nextRand());
		readAllBack();
		checkOutBytes();
	endtask

	task automatic testUnmapped();
		logic [blockAdrsWidth-1:0] pastEnd;
		pastEnd = blockAdrsWidth'(blockCount) + blockBase;
		writeAndCheck('0, 8'd0, nextRand());
		readAndCheck('0, 8'd1);
		writeAndCheck(pastEnd, 8'd2, nextRand());
		readAndCheck(pastEnd, 8'd3);
		readAllBack();
		checkOutBytes();
	endtask

	task automatic testCsrOutOfRange();
		for (int b = 0; b < blockCount; b++)
		begin
			writeAndCheck(blockAdrsWidth'(b) + blockBase, csrAdrsWidth'(csrDepth), nextRand());
			readAndCheck(blockAdrsWidth'(b) + blockBase, csrAdrsWidth'(csrDepth));
		end
		readAllBack();
		checkOutBytes();
	endtask

	// Watchdog
	initial
	begin
		#(watchdogNs);
		abortRun($sformatf("Watchdog expired after %0d ns, run did not finish", watchdogNs));
	end

	initial
	begin
		sysClk   = 1'b0;
		arstN    = 1'b0;
		req      = 1'b0;
		reqData  = '0;
		lcgState = 32'h434f;
		for (int b = 0; b < blockCount; b++)
			for (int c = 0; c < csrDepth; c++)
				model[b][c] = '0;
		repeat (resetCycles) @(posedge sysClk);
		#1;
		arstN = 1'b1;
		@(posedge sysClk);
		#1;
		testResetState();
		testWriteReadBack();
		testUnmapped();
		testCsrOutOfRange();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== usiSystem.f ====
hw/usiPkg.sv
hw/usiMasterPort.sv
hw/usiDecoder.sv
hw/csrBlock.sv
hw/usiReadMux.sv
hw/usiSystem.sv
testbench/usiSystem_chk.sv
testbench/usiSystemTb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Compile and run the usiSystem regression with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module usiSystemTb \
	-f usiSystem.f \
	-o usiSystemSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/usiSystemSim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
